// File: hw/rv_mem_macros.svh
`ifndef RV_MEM_MACROS_SVH
`define RV_MEM_MACROS_SVH

// Integer register width
`define XLEN 64

// Byte address width
`define ALEN 64

// Number of 64-bit lines in the data RAM
`define RAM_LINES 16

`endif

// File: hw/rv_mem_pkg.sv
`include "rv_mem_macros.svh"

package rv_mem_pkg;

    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        STORE    = 5'b01000,
        AMO      = 5'b01011
    } opcode_e;

    typedef enum logic [1:0] {
        BYTE  = 2'b00,
        HALF  = 2'b01,
        WORD  = 2'b10,
        DWORD = 2'b11
    } access_size_e;

    // funct7[6:2] of the A extension
    typedef enum logic [4:0] {
        ADD  = 5'b00000,
        SWAP = 5'b00001,
        LR   = 5'b00010,
        SC   = 5'b00011,
        XOR  = 5'b00100,
        OR   = 5'b01000,
        AND  = 5'b01100,
        MIN  = 5'b10000,
        MAX  = 5'b10100,
        MINU = 5'b11000,
        MAXU = 5'b11100
    } amo_func_e;

    typedef enum logic [3:0] {
        ILLEGAL_INSTR    = 4'd2,
        LOAD_MISALIGNED  = 4'd4,
        LOAD_FAULT       = 4'd5,
        STORE_MISALIGNED = 4'd6,
        STORE_FAULT      = 4'd7
    } trap_cause_e;

    typedef logic [`ALEN-4:0] line_addr_t;    // Address without the byte offset
    typedef logic [`XLEN/8-1:0] byte_mask_t;  // One bit per byte of a line

endpackage

// File: hw/addr_gen.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module addr_gen import rv_mem_pkg::*; (
    input  logic [4:0]       opcode,
    input  logic [2:0]       funct3,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [11:0]      i_imm,
    input  logic [11:0]      s_imm,
    output logic [`ALEN-1:0] eff_addr,
    output line_addr_t       line_addr,
    output logic [2:0]       line_offset,
    output logic             misaligned
);

    logic [11:0]  imm;
    access_size_e size;

    always_comb begin
        case (opcode)
            AMO:     imm = 12'd0;      // AMOs address rs1 directly
            STORE:   imm = s_imm;
            default: imm = i_imm;
        endcase
    end

    assign eff_addr    = rs1_data + {{(`ALEN-12){imm[11]}}, imm};
    assign line_addr   = eff_addr[`ALEN-1:3];
    assign line_offset = eff_addr[2:0];
    assign size        = access_size_e'(funct3[1:0]);

    // Any access that is not naturally aligned is rejected
    always_comb begin
        case (size)
            HALF:    misaligned = line_offset[0];
            WORD:    misaligned = |line_offset[1:0];
            DWORD:   misaligned = |line_offset;
            default: misaligned = 1'b0;
        endcase
    end

endmodule

// File: hw/load_align.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module load_align import rv_mem_pkg::*; (
    input  logic [`XLEN-1:0] ram_rdata,
    input  logic [2:0]       offset_q,
    input  access_size_e     size_q,
    input  logic             unsigned_q,
    output logic [`XLEN-1:0] load_value,
    output logic [31:0]      load_word
);

    logic [`XLEN-1:0] shifted;

    assign shifted   = ram_rdata >> {offset_q, 3'b000};   // Addressed byte moved to bit 0
    assign load_word = shifted[31:0];

    always_comb begin
        case (size_q)
            BYTE: begin
                if (unsigned_q)
                    load_value = {{(`XLEN-8){1'b0}}, shifted[7:0]};
                else
                    load_value = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            HALF: begin
                if (unsigned_q)
                    load_value = {{(`XLEN-16){1'b0}}, shifted[15:0]};
                else
                    load_value = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            WORD: begin
                // LR.W and AMO*.W also land here, always sign-extended
                if (unsigned_q)
                    load_value = {{(`XLEN-32){1'b0}}, shifted[31:0]};
                else
                    load_value = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
            end
            default: load_value = ram_rdata;                  // Whole line
        endcase
    end

endmodule

// File: hw/store_format.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module store_format import rv_mem_pkg::*; (
    input  access_size_e     size,
    input  logic [2:0]       offset,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] amo_data,
    input  logic             amo_store,
    output logic [`XLEN-1:0] ram_wdata,
    output byte_mask_t       ram_wmask
);

    logic [`XLEN-1:0] src;

    assign src = amo_store ? amo_data : rs2_data;     // ALU result on the AMO store

    // The field is copied into every slot, the mask picks the addressed one
    always_comb begin
        case (size)
            BYTE: begin
                ram_wdata = {(`XLEN/8){src[7:0]}};
                ram_wmask = byte_mask_t'(1) << offset;
            end
            HALF: begin
                ram_wdata = {(`XLEN/16){src[15:0]}};
                ram_wmask = byte_mask_t'(2'b11) << {offset[2:1], 1'b0};
            end
            WORD: begin
                ram_wdata = {(`XLEN/32){src[31:0]}};
                ram_wmask = byte_mask_t'(4'hf) << {offset[2], 2'b00};
            end
            default: begin
                ram_wdata = src;
                ram_wmask = '1;
            end
        endcase
    end

endmodule

// File: hw/amo_alu.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module amo_alu import rv_mem_pkg::*; (
    input  amo_func_e        amo_func,
    input  access_size_e     size,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] load_value,
    input  logic [31:0]      load_word,
    output logic [`XLEN-1:0] amo_value
);

    logic [31:0]      rs2_w;
    logic [31:0]      res_w;
    logic [`XLEN-1:0] res_d;

    assign rs2_w = rs2_data[31:0];   // Upper rs2 bits ignored for .W

    always_comb begin
        case (amo_func)
            SWAP: begin
                res_w = rs2_w;
                res_d = rs2_data;
            end
            ADD: begin
                res_w = rs2_w + load_word;
                res_d = rs2_data + load_value;
            end
            XOR: begin
                res_w = rs2_w ^ load_word;
                res_d = rs2_data ^ load_value;
            end
            AND: begin
                res_w = rs2_w & load_word;
                res_d = rs2_data & load_value;
            end
            OR: begin
                res_w = rs2_w | load_word;
                res_d = rs2_data | load_value;
            end
            MIN: begin
                res_w = $signed(rs2_w) < $signed(load_word) ? rs2_w : load_word;
                res_d = $signed(rs2_data) < $signed(load_value) ? rs2_data : load_value;
            end
            MAX: begin
                res_w = $signed(rs2_w) > $signed(load_word) ? rs2_w : load_word;
                res_d = $signed(rs2_data) > $signed(load_value) ? rs2_data : load_value;
            end
            MINU: begin
                res_w = rs2_w < load_word ? rs2_w : load_word;
                res_d = rs2_data < load_value ? rs2_data : load_value;
            end
            MAXU: begin
                res_w = rs2_w > load_word ? rs2_w : load_word;
                res_d = rs2_data > load_value ? rs2_data : load_value;
            end
            default: begin                        // LR/SC never reach the store step
                res_w = load_word;
                res_d = load_value;
            end
        endcase
    end

    assign amo_value = size == WORD ? {(`XLEN/32){res_w}} : res_d;

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module data_ram import rv_mem_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             ram_req,
    input  logic             ram_we,
    input  line_addr_t       ram_addr,
    input  logic [`XLEN-1:0] ram_wdata,
    input  byte_mask_t       ram_wmask,
    output logic             ram_ack,
    output logic [`XLEN-1:0] ram_rdata,
    output logic             ram_fault
);

    localparam int IDX_W = $clog2(`RAM_LINES);

    logic [`XLEN-1:0] mem [`RAM_LINES];
    line_addr_t       last_line;           // Line of the previous request
    line_addr_t       addr_q;
    logic             we_q;
    logic [`XLEN-1:0] wdata_q;
    byte_mask_t       wmask_q;
    logic [1:0]       wait_cnt;            // Ack when it reaches 1
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign in_range  = addr_q < `RAM_LINES;
    assign idx       = addr_q[IDX_W-1:0];
    assign ram_ack   = wait_cnt == 2'd1;
    assign ram_fault = !in_range;
    assign ram_rdata = in_range ? mem[idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt  <= 2'd0;
            last_line <= '0;
            for (int i = 0; i < `RAM_LINES; i++)
                mem[i] <= '0;
        end else begin
            if (ram_req) begin
                wait_cnt  <= ram_addr == last_line ? 2'd1 : 2'd3;   // Same line is fast
                last_line <= ram_addr;
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            // Write lands at the end of the ack cycle, faulting lines are untouched
            if (ram_ack && we_q && in_range) begin
                for (int b = 0; b < `XLEN/8; b++)
                    if (wmask_q[b])
                        mem[idx][b*8 +: 8] <= wdata_q[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_req) begin
            addr_q  <= ram_addr;
            we_q    <= ram_we;
            wdata_q <= ram_wdata;
            wmask_q <= ram_wmask;
        end
    end

endmodule

// File: hw/mem_ctrl.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module mem_ctrl import rv_mem_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [4:0]       opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  line_addr_t       line_addr,
    input  logic [2:0]       line_offset,
    input  logic             misaligned,
    input  logic [`ALEN-1:0] eff_addr,
    input  logic [`XLEN-1:0] load_value,
    input  logic [`XLEN-1:0] amo_value,
    input  logic             ram_ack,
    input  logic             ram_fault,
    output logic             ram_req,
    output logic             ram_we,
    output line_addr_t       ram_addr,
    output logic             amo_store,
    output logic [`XLEN-1:0] amo_data,
    output access_size_e     size_q,
    output logic             unsigned_q,
    output logic [2:0]       offset_q,
    output amo_func_e        amo_func_q,
    output logic             out_valid,
    output logic             exception,
    output trap_cause_e      trap_cause,
    output logic [`ALEN-1:0] fault_addr,
    output logic [`XLEN-1:0] result
);

    typedef enum logic [1:0] {IDLE, WAIT_LOAD, AMO_STORE, WAIT_STORE} state_e;

    state_e    state;
    logic      reserved;          // LR/SC reservation flag
    amo_func_e func;
    logic      is_store, is_fence, is_amo, is_lr, is_sc;
    logic      amo_known, illegal, writes, store_side, sc_fail, done_now;

    assign func       = amo_func_e'(funct7[6:2]);
    assign is_store   = opcode == STORE;
    assign is_fence   = opcode == MISC_MEM;
    assign is_amo     = opcode == AMO;
    assign is_lr      = is_amo && func == LR;
    assign is_sc      = is_amo && func == SC;
    assign writes     = is_store || is_sc;
    assign store_side = is_store || (is_amo && !is_lr);   // Store/AMO causes
    assign sc_fail    = is_sc && !reserved;
    assign done_now   = illegal || is_fence || misaligned || sc_fail;

    always_comb begin
        case (func)
            LR, SC, SWAP, ADD, XOR, AND, OR, MIN, MAX, MINU, MAXU: amo_known = 1'b1;
            default: amo_known = 1'b0;
        endcase
        case (opcode)
            LOAD:     illegal = funct3 == 3'b111;
            STORE:    illegal = funct3[2];
            MISC_MEM: illegal = funct3 != 3'b000;            // Only a plain FENCE
            AMO:      illegal = funct3[2:1] != 2'b01 || !amo_known;
            default:  illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            out_valid <= 1'b0;
            ram_req   <= 1'b0;
            ram_we    <= 1'b0;
            reserved  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            ram_req   <= 1'b0;
            ram_we    <= 1'b0;
            case (state)
                IDLE: if (in_valid) begin
                    if (done_now) begin
                        out_valid <= 1'b1;
                    end else begin
                        ram_req <= 1'b1;
                        ram_we  <= writes;
                        state   <= writes ? WAIT_STORE : WAIT_LOAD;
                    end
                    if (!illegal && writes)
                        reserved <= 1'b0;
                    else if (!illegal && is_lr && !misaligned)
                        reserved <= 1'b1;
                end
                WAIT_LOAD: if (ram_ack) begin
                    if (amo_store && !ram_fault) begin
                        state <= AMO_STORE;               // ALU step
                    end else begin
                        out_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                AMO_STORE: begin
                    ram_req <= 1'b1;
                    ram_we  <= 1'b1;
                    state   <= WAIT_STORE;
                end
                WAIT_STORE: if (ram_ack) begin
                    out_valid <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction fields, result and trap payload
    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            ram_addr   <= line_addr;
            offset_q   <= line_offset;
            size_q     <= access_size_e'(funct3[1:0]);
            unsigned_q <= funct3[2];
            amo_func_q <= func;
            amo_store  <= is_amo && !is_lr && !is_sc;     // Read-modify-write AMO
            fault_addr <= eff_addr;
            result     <= {{(`XLEN-1){1'b0}}, sc_fail};   // SC reports 1 on failure
            exception  <= illegal || (!is_fence && misaligned);
            if (illegal)
                trap_cause <= ILLEGAL_INSTR;
            else
                trap_cause <= store_side ? STORE_MISALIGNED : LOAD_MISALIGNED;
        end
        if (state == WAIT_LOAD && ram_ack) begin
            result     <= ram_fault ? '0 : load_value;    // Old value for LR and AMOs
            amo_data   <= amo_value;
            exception  <= ram_fault;
            trap_cause <= amo_store ? STORE_FAULT : LOAD_FAULT;
        end
        if (state == WAIT_STORE && ram_ack) begin
            exception  <= ram_fault;
            trap_cause <= STORE_FAULT;
        end
    end

endmodule

// File: hw/mem_stage_top.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module mem_stage_top import rv_mem_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [4:0]       opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [11:0]      i_imm,
    input  logic [11:0]      s_imm,
    output logic             out_valid,
    output logic             exception,
    output trap_cause_e      trap_cause,
    output logic [`ALEN-1:0] fault_addr,
    output logic [`XLEN-1:0] result
);

    logic [`ALEN-1:0] eff_addr;
    line_addr_t       line_addr;
    logic [2:0]       line_offset;
    logic             misaligned;
    logic [`XLEN-1:0] load_value;
    logic [31:0]      load_word;
    logic [`XLEN-1:0] amo_value;
    logic [`XLEN-1:0] amo_data;
    logic             amo_store;
    access_size_e     size_q;
    logic             unsigned_q;
    logic [2:0]       offset_q;
    amo_func_e        amo_func_q;
    logic             ram_req;
    logic             ram_we;
    line_addr_t       ram_addr;
    logic [`XLEN-1:0] ram_wdata;
    byte_mask_t       ram_wmask;
    logic             ram_ack;
    logic [`XLEN-1:0] ram_rdata;
    logic             ram_fault;

    addr_gen u_addr_gen (
        .opcode(opcode), .funct3(funct3), .rs1_data(rs1_data), .i_imm(i_imm),
        .s_imm(s_imm), .eff_addr(eff_addr), .line_addr(line_addr),
        .line_offset(line_offset), .misaligned(misaligned)
    );

    mem_ctrl u_ctrl (
        .clk(clk), .rst(rst), .in_valid(in_valid), .opcode(opcode), .funct3(funct3),
        .funct7(funct7), .line_addr(line_addr), .line_offset(line_offset),
        .misaligned(misaligned), .eff_addr(eff_addr), .load_value(load_value),
        .amo_value(amo_value), .ram_ack(ram_ack), .ram_fault(ram_fault),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr), .amo_store(amo_store),
        .amo_data(amo_data), .size_q(size_q), .unsigned_q(unsigned_q),
        .offset_q(offset_q), .amo_func_q(amo_func_q), .out_valid(out_valid),
        .exception(exception), .trap_cause(trap_cause), .fault_addr(fault_addr),
        .result(result)
    );

    load_align u_load_align (
        .ram_rdata(ram_rdata), .offset_q(offset_q), .size_q(size_q),
        .unsigned_q(unsigned_q), .load_value(load_value), .load_word(load_word)
    );

    store_format u_store_format (
        .size(size_q), .offset(line_offset), .rs2_data(rs2_data), .amo_data(amo_data),
        .amo_store(amo_store), .ram_wdata(ram_wdata), .ram_wmask(ram_wmask)
    );

    amo_alu u_amo_alu (
        .amo_func(amo_func_q), .size(size_q), .rs2_data(rs2_data),
        .load_value(load_value), .load_word(load_word), .amo_value(amo_value)
    );

    data_ram u_ram (
        .clk(clk), .rst(rst), .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_wmask(ram_wmask), .ram_ack(ram_ack),
        .ram_rdata(ram_rdata), .ram_fault(ram_fault)
    );

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;   // Half period high, half low

endmodule

// File: tests/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions (
    input logic       clk,
    input logic       rst,
    input logic       in_valid,
    input logic [1:0] state,
    input logic       ram_req,
    input logic       ram_we,
    input logic       out_valid,
    input logic       is_sc,
    input logic       reserved
);

    // Encoding of the mem_ctrl FSM states
    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_WAIT_LOAD  = 2'd1;
    localparam logic [1:0] ST_WAIT_STORE = 2'd3;

    no_input_while_busy: assert property (@(posedge clk) disable iff (rst)
        state != ST_IDLE |-> !in_valid)
        else $error("in_valid arrived while mem_ctrl was busy");

    req_in_wait_state: assert property (@(posedge clk) disable iff (rst)
        ram_req |-> state == ST_WAIT_LOAD || state == ST_WAIT_STORE)
        else $error("ram_req raised outside a request state");

    out_valid_single: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid held for more than one cycle");

    failed_sc_no_write: assert property (@(posedge clk) disable iff (rst)
        state == ST_IDLE && in_valid && is_sc && !reserved |=> !ram_we)
        else $error("SC without reservation wrote to the RAM");

endmodule

// File: tests/mem_stage_tb.sv
`timescale 1ns/1ps
`include "rv_mem_macros.svh"

module mem_stage_tb import rv_mem_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 151;              // Instructions issued below
    localparam int MEM_BYTES  = `RAM_LINES * 8;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [4:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [63:0]      rs1_data;
    logic [63:0]      rs2_data;
    logic [11:0]      i_imm;
    logic [11:0]      s_imm;
    logic             out_valid;
    logic             exception;
    trap_cause_e      trap_cause;
    logic [63:0]      fault_addr;
    logic [63:0]      result;

    logic [7:0]       model_mem [MEM_BYTES];   // Byte copy of the data RAM
    logic             model_rsv;
    logic [63:0]      exp_result_q [$];
    logic             exp_exc_q [$];
    logic [3:0]       exp_cause_q [$];
    logic [63:0]      exp_addr_q [$];
    logic [63:0]      want_res;
    logic             want_exc;
    logic [3:0]       want_cause;
    logic [63:0]      want_addr;
    logic [4:0]       amo_ops [9];
    int               errors;
    int               checks;
    int               issued;
    int               done_count;
    integer           seed;

    clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    mem_stage_top dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .opcode(opcode), .funct3(funct3),
        .funct7(funct7), .rs1_data(rs1_data), .rs2_data(rs2_data), .i_imm(i_imm),
        .s_imm(s_imm), .out_valid(out_valid), .exception(exception),
        .trap_cause(trap_cause), .fault_addr(fault_addr), .result(result)
    );

    bind mem_ctrl mem_stage_assertions u_assertions (
        .clk(clk), .rst(rst), .in_valid(in_valid), .state(state), .ram_req(ram_req),
        .ram_we(ram_we), .out_valid(out_valid), .is_sc(is_sc), .reserved(reserved)
    );

    function automatic logic [63:0] rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] rand_addr(logic [2:0] f3);
        logic [6:0] a;
        a = 7'(rnd64());
        a = a & ~7'((1 << f3[1:0]) - 1);          // Natural alignment
        return {57'd0, a};
    endfunction

    function automatic logic [63:0] read_model(logic [63:0] addr, int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v[i*8 +: 8] = model_mem[int'(addr[6:0]) + i];   // Little endian
        return v;
    endfunction

    function automatic void write_model(logic [63:0] addr, int n, logic [63:0] data);
        for (int i = 0; i < n; i++)
            model_mem[int'(addr[6:0]) + i] = data[i*8 +: 8];
    endfunction

    function automatic logic [63:0] extend(logic [63:0] v, int n, logic uns);
        logic [63:0] m;
        m = (n == 8) ? '1 : ((64'd1 << (n * 8)) - 64'd1);
        v = v & m;
        if (!uns && n < 8 && v[n*8-1])
            v = v | ~m;
        return v;
    endfunction

    function automatic logic [63:0] amo_calc(logic [4:0] func, logic [63:0] a,
                                             logic [63:0] b, int n);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        sa = extend(a, n, 1'b0);
        sb = extend(b, n, 1'b0);
        ua = extend(a, n, 1'b1);
        ub = extend(b, n, 1'b1);
        case (func)
            SWAP:    return b;
            ADD:     return a + b;
            XOR:     return a ^ b;
            AND:     return a & b;
            OR:      return a | b;
            MIN:     return $signed(sb) < $signed(sa) ? b : a;
            MAX:     return $signed(sb) > $signed(sa) ? b : a;
            MINU:    return ub < ua ? b : a;
            default: return ub > ua ? b : a;   // MAXU
        endcase
    endfunction

    // Expected outcome of one instruction and its effect on the memory and reservation model
    function automatic void predict(input logic [4:0] op, input logic [2:0] f3,
                                    input logic [6:0] f7, input logic [63:0] rs1,
                                    input logic [63:0] rs2, input logic [11:0] ii,
                                    input logic [11:0] si, output logic [63:0] res,
                                    output logic exc, output logic [3:0] cause,
                                    output logic [63:0] addr);
        logic [11:0] imm;
        logic [4:0]  func;
        logic [63:0] old;
        logic        legal;
        logic        wr_side;
        logic        is_lr;
        logic        is_sc;
        logic        sc_ok;
        int          n;
        func    = f7[6:2];
        imm     = op == AMO ? 12'd0 : (op == STORE ? si : ii);
        addr    = rs1 + {{52{imm[11]}}, imm};
        n       = 1 << f3[1:0];
        is_lr   = op == AMO && func == LR;
        is_sc   = op == AMO && func == SC;
        wr_side = op == STORE || (op == AMO && !is_lr);
        sc_ok   = 1'b0;
        res     = '0;
        exc     = 1'b0;
        cause   = 4'd0;
        case (op)
            LOAD:     legal = f3 != 3'b111;
            STORE:    legal = !f3[2];
            MISC_MEM: legal = f3 == 3'b000;
            AMO:      legal = (f3 == 3'b010 || f3 == 3'b011) &&
                              func inside {LR, SC, SWAP, ADD, XOR, AND, OR, MIN, MAX, MINU, MAXU};
            default:  legal = 1'b0;
        endcase
        if (!legal) begin
            exc   = 1'b1;
            cause = ILLEGAL_INSTR;
            return;
        end
        if (op == MISC_MEM)
            return;                                // FENCE has nothing to order
        if (op == STORE || is_sc) begin
            sc_ok     = model_rsv;
            model_rsv = 1'b0;
        end
        if ((addr[2:0] & 3'(n - 1)) != 3'd0) begin
            exc   = 1'b1;
            cause = wr_side ? STORE_MISALIGNED : LOAD_MISALIGNED;
            return;
        end
        if (is_lr)
            model_rsv = 1'b1;
        if (is_sc && !sc_ok) begin
            res = 64'd1;
            return;
        end
        if (addr >= 64'(MEM_BYTES)) begin
            exc   = 1'b1;
            cause = wr_side ? STORE_FAULT : LOAD_FAULT;
            return;
        end
        if (op == STORE || is_sc) begin
            write_model(addr, n, rs2);
            return;
        end
        old = extend(read_model(addr, n), n, op == LOAD && f3[2]);
        res = old;
        if (op == AMO && !is_lr)
            write_model(addr, n, amo_calc(func, old, rs2, n));
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic run_op(input logic [4:0] op, input logic [2:0] f3, input logic [6:0] f7,
                          input logic [63:0] rs1, input logic [63:0] rs2,
                          input logic [11:0] ii, input logic [11:0] si);
        logic [63:0] res;
        logic        exc;
        logic [3:0]  cause;
        logic [63:0] addr;
        predict(op, f3, f7, rs1, rs2, ii, si, res, exc, cause, addr);
        exp_result_q.push_back(res);
        exp_exc_q.push_back(exc);
        exp_cause_q.push_back(cause);
        exp_addr_q.push_back(addr);
        @(posedge clk);
        #1;
        opcode   = op;
        funct3   = f3;
        funct7   = f7;
        rs1_data = rs1;
        rs2_data = rs2;
        i_imm    = ii;
        s_imm    = si;
        in_valid = 1'b1;
        issued++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;                           // Fields stay until out_valid
        wait (done_count == issued);
    endtask

    task automatic load_at(input logic [2:0] f3, input logic [63:0] addr);
        logic [11:0] imm;
        imm = 12'(rnd64());
        run_op(LOAD, f3, 7'd0, addr - {{52{imm[11]}}, imm}, rnd64(), imm, 12'(rnd64()));
    endtask

    task automatic store_at(input logic [2:0] f3, input logic [63:0] addr,
                            input logic [63:0] data);
        logic [11:0] imm;
        imm = 12'(rnd64());
        run_op(STORE, f3, 7'd0, addr - {{52{imm[11]}}, imm}, data, 12'(rnd64()), imm);
    endtask

    task automatic atomic_at(input logic [4:0] func, input logic [2:0] f3,
                             input logic [63:0] addr, input logic [63:0] rs2);
        run_op(AMO, f3, {func, 2'b00}, addr, rs2, 12'(rnd64()), 12'(rnd64()));
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (exp_result_q.size() == 0) begin
                errors++;
                $display("out_valid arrived with no instruction outstanding");
            end else begin
                want_res   = exp_result_q.pop_front();
                want_exc   = exp_exc_q.pop_front();
                want_cause = exp_cause_q.pop_front();
                want_addr  = exp_addr_q.pop_front();
                check_value("exception", 64'(exception), 64'(want_exc));
                check_value("result", result, want_res);
                if (want_exc) begin
                    check_value("trap_cause", 64'(trap_cause), 64'(want_cause));
                    check_value("fault_addr", fault_addr, want_addr);
                end
                done_count++;
            end
        end
    end

    initial begin
        #((TEST_COUNT * 20 + 5) * CLK_PERIOD);
        $display("timeout: %0d of %0d instructions completed", done_count, issued);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [2:0]  f3;
        logic [63:0] a;
        seed       = 32'h7eadd8cd;
        errors     = 0;
        checks     = 0;
        issued     = 0;
        done_count = 0;
        model_rsv  = 1'b0;
        amo_ops    = '{SWAP, ADD, XOR, AND, OR, MIN, MAX, MINU, MAXU};
        for (int i = 0; i < MEM_BYTES; i++)
            model_mem[i] = 8'h00;
        rst      = 1'b1;
        in_valid = 1'b0;
        opcode   = '0;
        funct3   = '0;
        funct7   = '0;
        rs1_data = '0;
        rs2_data = '0;
        i_imm    = '0;
        s_imm    = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int l = 0; l < `RAM_LINES; l++)
            store_at(3'b011, 64'(l * 8), rnd64());
        for (int i = 0; i < 24; i++) begin
            f3 = 3'(i % 4);
            store_at(f3, rand_addr(f3), rnd64());
        end
        for (int i = 0; i < 42; i++) begin         // LB LH LW LD LBU LHU LWU
            f3 = 3'(i % 7);
            load_at(f3, rand_addr(f3));
        end

        load_at(3'b001, 64'd9);
        load_at(3'b010, 64'd18);
        load_at(3'b110, 64'd21);
        load_at(3'b011, 64'd36);
        store_at(3'b001, 64'd41, rnd64());
        store_at(3'b010, 64'd50, rnd64());
        store_at(3'b011, 64'd60, rnd64());
        for (int l = 5; l < 8; l++)
            load_at(3'b011, 64'(l * 8));           // Lines must be untouched

        load_at(3'b011, 64'd128);
        store_at(3'b010, 64'h400, rnd64());
        load_at(3'b000, 64'hffff_ffff_ffff_fff0);
        store_at(3'b000, 64'h8000_0000_0000_0000, rnd64());
        load_at(3'b011, 64'd0);                    // Low index bits of both faulting stores

        atomic_at(LR, 3'b011, 64'd16, rnd64());
        atomic_at(SC, 3'b011, 64'd16, rnd64());
        load_at(3'b011, 64'd16);
        atomic_at(SC, 3'b011, 64'd16, rnd64());    // No reservation left
        load_at(3'b011, 64'd16);
        atomic_at(LR, 3'b010, 64'd24, rnd64());
        store_at(3'b000, 64'd100, rnd64());
        atomic_at(SC, 3'b010, 64'd24, rnd64());
        load_at(3'b010, 64'd24);
        atomic_at(LR, 3'b010, 64'd28, rnd64());
        atomic_at(SC, 3'b010, 64'd28, rnd64());
        load_at(3'b110, 64'd28);

        for (int i = 0; i < 9; i++) begin
            for (int w = 0; w < 2; w++) begin
                f3 = w == 1 ? 3'b011 : 3'b010;
                a  = rand_addr(f3);
                atomic_at(amo_ops[i], f3, a, rnd64());
                load_at(f3, a);
            end
        end

        run_op(MISC_MEM, 3'b000, 7'd0, rnd64(), 64'd0, 12'(rnd64()), 12'd0);
        run_op(MISC_MEM, 3'b001, 7'd0, rnd64(), 64'd0, 12'(rnd64()), 12'd0);
        run_op(5'b01100, 3'b000, 7'd0, rnd64(), 64'd0, 12'(rnd64()), 12'd0);
        run_op(5'b11011, 3'b000, 7'd0, rnd64(), 64'd0, 12'(rnd64()), 12'd0);
        run_op(LOAD, 3'b111, 7'd0, 64'd8, 64'd0, 12'd0, 12'd0);
        run_op(AMO, 3'b000, {ADD, 2'b00}, 64'd8, rnd64(), 12'd0, 12'd0);

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/rv_mem_pkg.sv
hw/addr_gen.sv
hw/load_align.sv
hw/store_format.sv
hw/amo_alu.sv
hw/data_ram.sv
hw/mem_ctrl.sv
hw/mem_stage_top.sv
tests/clk_gen.sv
tests/mem_stage_assertions.sv
tests/mem_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := mem_stage_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
